//--- verification/ddr_persona_golden.txt
# name base(hex) count seed(hex) inject clr exp_errors exp_words exp_pass
# A clr of 1 aborts the run midway, so every count reads back as zero
clean_small 00 4 00000001 0 0 0 4 1
clean_mid 10 16 deadbeef 0 0 0 16 1
clean_wrap 3a 12 fffffffa 0 0 0 12 1
clean_full 00 64 12345678 0 0 0 64 1
clean_clamp 20 100 a5a5a5a5 0 0 0 64 1
clean_odd 21 33 00000100 0 0 0 33 1
base_wide 1234567f 6 80000000 0 0 0 6 1
inject_run 05 8 00000000 1 0 1 8 0
inject_single 3f 1 cafef00d 1 0 1 1 0
inject_wrap 3e 5 ffffffff 1 0 1 5 0
inject_empty 0c 0 11111111 1 0 0 0 1
count_zero 00 0 00000000 0 0 0 0 1
abort_run 08 40 0badcafe 0 1 0 0 0
after_abort 08 40 0badcafe 0 0 0 40 1

//--- src.f
logic/ddr_persona_pkg.sv
logic/persona_ifs.sv
logic/persona_reg_decode.sv
logic/mem_access.sv
logic/traffic_generator.sv
logic/access_result.sv
logic/ddr_persona_top.sv
verification/ddr_persona_checker.sv
verification/ddr_persona_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ddr_persona_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= sim passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/ddr_persona_tb.sv
// DDR persona testbench
`timescale 1ns/1ps

module ddr_persona_tb;
   import ddr_persona_pkg::*;

   localparam int    clk_period   = 40;
   localparam int    reset_cycles = 16;
   // Register traffic and FSM overhead allowed per test on top of 2 x count
   localparam int    slack_cycles = 40;
   localparam string golden_path  = "verification/ddr_persona_golden.txt";

   // One golden line, fields in file order
   typedef struct packed {
      logic [8*24-1:0] name;
      logic [31:0]     base;
      logic [31:0]     count;
      logic [31:0]     seed;
      logic [31:0]     inject;
      logic [31:0]     clr;
      logic [31:0]     errors;
      logic [31:0]     words;
      logic [31:0]     pass;
   } golden_t;

   logic                      pr_region_clk;
   logic                      rst_n;
   logic [reg_addr_width-1:0] reg_address;
   logic                      reg_write;
   logic                      reg_read;
   logic [data_width-1:0]     reg_writedata;
   logic [data_width-1:0]     reg_readdata;
   golden_t                   tests [$];
   logic                      loaded;
   int unsigned               watchdog_cycles;

   ddr_persona_top i_dut (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .reg_address   (reg_address),
      .reg_write     (reg_write),
      .reg_read      (reg_read),
      .reg_writedata (reg_writedata),
      .reg_readdata  (reg_readdata)
   );

   // Protocol assertions ride along inside the controller
   bind mem_access ddr_persona_checker i_checker (
      .pr_region_clk           (pr_region_clk),
      .rst_n                   (rst_n),
      .busy                    (busy),
      .start_traffic_generator (start_traffic_generator),
      .clear_start_operation   (clear_start_operation),
      .ddr_access_completed    (acc.ddr_access_completed)
   );

   always #(clk_period / 2) pr_region_clk = ~pr_region_clk;

   ////////////////////////////////////////////////////////////
   // Register port helpers
   ////////////////////////////////////////////////////////////

   task automatic compare_value(input logic [8*24-1:0] test, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %0s %0s expected 0x%08h actual 0x%08h", test, what, expected, actual);
         $display("sim failed");
         $fatal(1, "Register readback mismatch");
      end
   endtask

   // The DUT samples the strobe on the edge after it is driven
   task automatic write_register(input logic [2:0] addr, input logic [31:0] data);
      @(posedge pr_region_clk);
      reg_address   <= addr;
      reg_writedata <= data;
      reg_write     <= 1'b1;
      @(posedge pr_region_clk);
      reg_write <= 1'b0;
   endtask

   task automatic read_register(input logic [2:0] addr, output logic [31:0] data);
      @(posedge pr_region_clk);
      reg_address <= addr;
      reg_read    <= 1'b1;
      @(posedge pr_region_clk);
      reg_read <= 1'b0;
      // Registered read data is stable by the falling edge
      @(negedge pr_region_clk);
      data = reg_readdata;
   endtask

   // Poll status until busy is low and done is set
   task automatic wait_for_done(output logic [31:0] status);
      do begin
         read_register(reg_status, status);
      end while (status[stat_busy_bit] || !status[stat_done_bit]);
   endtask

   task automatic wait_for_busy();
      logic [31:0] status;
      do begin
         read_register(reg_status, status);
      end while (!status[stat_busy_bit]);
   endtask

   ////////////////////////////////////////////////////////////
   // Golden file
   ////////////////////////////////////////////////////////////

   task automatic load_golden();
      int              fd;
      int              fields;
      string           line;
      golden_t         t;
      logic [8*24-1:0] name;
      logic [31:0]     v [8];
      fd = $fopen(golden_path, "r");
      if (fd == 0) begin
         $display("Could not open the golden file %0s", golden_path);
         $display("sim failed");
         $fatal(1, "Missing stimulus file");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            fields = $sscanf(line, "%s %h %d %h %d %d %d %d %d", name,
                             v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            if (fields == 9) begin
               t = {name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]};
               tests.push_back(t);
            end
         end
      end
      $fclose(fd);
      if (tests.size() == 0) begin
         $display("The golden file holds no test lines");
         $display("sim failed");
         $fatal(1, "Empty stimulus file");
      end
      // Each run needs count writes and count reads plus overhead
      watchdog_cycles = reset_cycles;
      foreach (tests[i]) begin
         watchdog_cycles += 2 * tests[i].count + slack_cycles;
      end
      loaded = 1'b1;
   endtask

   ////////////////////////////////////////////////////////////
   // One golden test
   ////////////////////////////////////////////////////////////

   task automatic run_test(input golden_t t);
      logic [31:0] data;
      logic [31:0] exp_count;
      logic [31:0] control;
      // Counts past the memory depth read back clamped
      exp_count = (t.count > mem_depth) ? 32'(mem_depth) : t.count;
      write_register(reg_base, t.base);
      write_register(reg_count, t.count);
      write_register(reg_seed, t.seed);
      read_register(reg_base, data);
      compare_value(t.name, "base", t.base, data);
      read_register(reg_count, data);
      compare_value(t.name, "count", exp_count, data);
      read_register(reg_seed, data);
      compare_value(t.name, "seed", t.seed, data);
      // Address 7 is outside the register map and reads as zero
      read_register(3'd7, data);
      compare_value(t.name, "unmapped_address", 32'd0, data);
      control                  = '0;
      control[ctrl_start_bit]  = 1'b1;
      control[ctrl_inject_bit] = t.inject[0];
      write_register(reg_control, control);
      if (t.clr[0]) begin
         // Abort part way through the read phase
         wait_for_busy();
         repeat (t.count + t.count / 2) @(posedge pr_region_clk);
         control               = '0;
         control[ctrl_clr_bit] = 1'b1;
         write_register(reg_control, control);
         read_register(reg_status, data);
         compare_value(t.name, "busy", 32'd0, 32'(data[stat_busy_bit]));
         compare_value(t.name, "done", 32'd0, 32'(data[stat_done_bit]));
      end else begin
         wait_for_done(data);
      end
      compare_value(t.name, "pass", t.pass, 32'(data[stat_pass_bit]));
      read_register(reg_error_count, data);
      compare_value(t.name, "error_count", t.errors, data);
      read_register(reg_words_checked, data);
      compare_value(t.name, "words_checked", t.words, data);
      // The controller drops the start bit once the run is over
      read_register(reg_control, data);
      compare_value(t.name, "start_bit", 32'd0, 32'(data[ctrl_start_bit]));
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      pr_region_clk = 1'b0;
      rst_n         = 1'b0;
      reg_address   = '0;
      reg_write     = 1'b0;
      reg_read      = 1'b0;
      reg_writedata = '0;
      loaded        = 1'b0;
      load_golden();
      repeat (reset_cycles) @(posedge pr_region_clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge pr_region_clk);
      foreach (tests[i]) begin
         run_test(tests[i]);
      end
      $display("sim passed");
      $finish;
   end

   initial begin
      wait (loaded);
      repeat (watchdog_cycles) @(posedge pr_region_clk);
      $display("Watchdog expired after %0d cycles, a run never finished", watchdog_cycles);
      $display("sim failed");
      $fatal(1, "Simulation timeout");
   end

endmodule

//--- verification/ddr_persona_checker.sv
// Controller protocol assertions
`timescale 1ns/1ps

module ddr_persona_checker (
   input logic pr_region_clk,
   input logic rst_n,
   input logic busy,
   input logic start_traffic_generator,
   input logic clear_start_operation,
   input logic ddr_access_completed
);

   ////////////////////////////////////////////////////////////
   // Controller output relations
   ////////////////////////////////////////////////////////////

   // Both outputs are decoded from the same ddr_access state
   busy_tracks_start: assert property (@(posedge pr_region_clk) disable iff (!rst_n)
      busy == start_traffic_generator)
      else $error("busy and start_traffic_generator disagree");

   // The start clear request is a single-cycle pulse
   clear_is_pulse: assert property (@(posedge pr_region_clk) disable iff (!rst_n)
      clear_start_operation |=> !clear_start_operation)
      else $error("clear_start_operation held high for two cycles");

   // Completion sends the FSM back to idle on the next edge
   busy_drops_after_done: assert property (@(posedge pr_region_clk) disable iff (!rst_n)
      ddr_access_completed |=> !busy)
      else $error("busy still high one cycle after completion");

endmodule

//--- logic/ddr_persona_top.sv
// DDR access persona top level
`timescale 1ns/1ps

module ddr_persona_top (
   input  logic                                       pr_region_clk,
   input  logic                                       rst_n,
   input  logic [ddr_persona_pkg::reg_addr_width-1:0] reg_address,
   input  logic                                       reg_write,
   input  logic                                       reg_read,
   input  logic [ddr_persona_pkg::data_width-1:0]     reg_writedata,
   output logic [ddr_persona_pkg::data_width-1:0]     reg_readdata
);
   import ddr_persona_pkg::*;

   logic [count_width-1:0] error_count;
   logic [count_width-1:0] words_checked;
   logic                   done;
   logic                   pass;

   persona_ctrl_if  ctrl_if ();
   access_result_if acc_if ();

   ////////////////////////////////////////////////////////////
   // Decode, execute and result stages
   ////////////////////////////////////////////////////////////

   persona_reg_decode i_reg_decode (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .reg_address   (reg_address),
      .reg_write     (reg_write),
      .reg_read      (reg_read),
      .reg_writedata (reg_writedata),
      .reg_readdata  (reg_readdata),
      .ctrl          (ctrl_if),
      .error_count   (error_count),
      .words_checked (words_checked),
      .done          (done),
      .pass          (pass)
   );

   mem_access i_mem_access (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .ctrl          (ctrl_if),
      .acc           (acc_if)
   );

   traffic_generator i_traffic_gen (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .ctrl          (ctrl_if),
      .acc           (acc_if)
   );

   access_result i_access_result (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .ctrl          (ctrl_if),
      .acc           (acc_if),
      .error_count   (error_count),
      .words_checked (words_checked),
      .done          (done),
      .pass          (pass)
   );

endmodule

//--- logic/access_result.sv
// Access result accumulator
`timescale 1ns/1ps

module access_result (
   input  logic                                    pr_region_clk,
   input  logic                                    rst_n,
   persona_ctrl_if.result                          ctrl,
   access_result_if.monitor                        acc,
   output logic [ddr_persona_pkg::count_width-1:0] error_count,
   output logic [ddr_persona_pkg::count_width-1:0] words_checked,
   output logic                                    done,
   output logic                                    pass
);
   import ddr_persona_pkg::*;

   logic start_q;
   logic run_start;

   // A new run is seen on the rising edge of the generator start level
   assign run_start = acc.start_traffic_generator && !start_q;

   always_ff @(posedge pr_region_clk or negedge rst_n) begin
      if (!rst_n) begin
         start_q       <= 1'b0;
         error_count   <= '0;
         words_checked <= '0;
         done          <= 1'b0;
         pass          <= 1'b0;
      end else begin
         start_q <= acc.start_traffic_generator;
         if (ctrl.clr_io_reg || run_start) begin
            error_count   <= '0;
            words_checked <= '0;
            done          <= 1'b0;
            pass          <= 1'b0;
         end else begin
            if (acc.check_valid) begin
               words_checked <= words_checked + 1'b1;
               if (acc.mismatch) begin
                  error_count <= error_count + 1'b1;
               end
            end
            // Completion trails the last compare, so the count is final here
            if (acc.ddr_access_completed) begin
               done <= 1'b1;
               pass <= (error_count == '0);
            end
         end
      end
   end

endmodule

//--- logic/traffic_generator.sv
// Pattern traffic generator
`timescale 1ns/1ps

module traffic_generator (
   input logic                pr_region_clk,
   input logic                rst_n,
   persona_ctrl_if.generator  ctrl,
   access_result_if.generator acc
);
   import ddr_persona_pkg::*;

   gen_state_t                state;
   logic [mem_addr_width-1:0] base_q;
   logic [count_width-1:0]    count_q;
   logic [data_width-1:0]     seed_q;
   logic                      inject_q;
   logic [count_width-1:0]    index;
   logic [data_width-1:0]     mem [mem_depth];
   logic [mem_addr_width-1:0] mem_addr;
   logic [data_width-1:0]     expected;
   logic [data_width-1:0]     write_data;
   logic [data_width-1:0]     rd_data;
   logic [data_width-1:0]     exp_q;
   logic                      mem_we;
   logic                      mem_re;
   logic                      rd_valid;
   logic                      completed;

   // Address arithmetic is 6 bits wide, so runs wrap past word 63
   assign mem_addr = base_q + index[mem_addr_width-1:0];
   assign expected = pattern_word(seed_q, index);
   // Error injection flips bit 0 of the first word only
   assign write_data = (inject_q && (index == '0)) ? (expected ^ data_width'(1)) : expected;
   assign mem_we   = (state == gen_write);
   assign mem_re   = (state == gen_read) && (index != count_q);

   ////////////////////////////////////////////////////////////
   // Stand-in memory and run parameters
   ////////////////////////////////////////////////////////////

   // Read data and its expected value are captured together
   always_ff @(posedge pr_region_clk) begin
      if (mem_we) begin
         mem[mem_addr] <= write_data;
      end
      if (mem_re) begin
         rd_data <= mem[mem_addr];
         exp_q   <= expected;
      end
   end

   // Host writes during a run are ignored until the next start
   always_ff @(posedge pr_region_clk) begin
      if ((state == gen_idle) && acc.start_traffic_generator) begin
         base_q   <= ctrl.base;
         count_q  <= ctrl.count;
         seed_q   <= ctrl.seed;
         inject_q <= ctrl.inject_error;
      end
   end

   ////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////

   always_ff @(posedge pr_region_clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= gen_idle;
         index     <= '0;
         rd_valid  <= 1'b0;
         completed <= 1'b0;
      end else if (ctrl.clr_io_reg) begin
         state     <= gen_idle;
         index     <= '0;
         rd_valid  <= 1'b0;
         completed <= 1'b0;
      end else begin
         rd_valid  <= mem_re;
         completed <= 1'b0;
         unique case (state)
            gen_idle: begin
               index <= '0;
               if (acc.start_traffic_generator) begin
                  // An empty run finishes straight away
                  if (ctrl.count == '0) begin
                     completed <= 1'b1;
                     state     <= gen_done;
                  end else begin
                     state <= gen_write;
                  end
               end
            end
            gen_write: begin
               if (index == count_q - 1'b1) begin
                  index <= '0;
                  state <= gen_read;
               end else begin
                  index <= index + 1'b1;
               end
            end
            gen_read: begin
               // Last compare lands while reads stop, completion follows it
               if (mem_re) begin
                  index <= index + 1'b1;
               end else begin
                  completed <= 1'b1;
                  state     <= gen_done;
               end
            end
            gen_done: begin
               if (!acc.start_traffic_generator) begin
                  state <= gen_idle;
               end
            end
         endcase
      end
   end

   assign acc.check_valid          = rd_valid;
   assign acc.mismatch             = rd_valid && (rd_data != exp_q);
   assign acc.ddr_access_completed = completed;

endmodule

//--- logic/mem_access.sv
// Memory access controller
`timescale 1ns/1ps

module mem_access (
   input logic              pr_region_clk,
   input logic              rst_n,
   persona_ctrl_if.execute  ctrl,
   access_result_if.control acc
);
   import ddr_persona_pkg::*;

   access_state_t curr_state;
   access_state_t next_state;
   logic          busy;
   logic          start_traffic_generator;
   logic          clear_start_operation;

   ////////////////////////////////////////////////////////////
   // State register
   ////////////////////////////////////////////////////////////

   // The clear pulse from the host aborts a run and parks the FSM
   always_ff @(posedge pr_region_clk or negedge rst_n) begin
      if (!rst_n) begin
         curr_state <= idle;
      end else if (ctrl.clr_io_reg) begin
         curr_state <= idle;
      end else begin
         curr_state <= next_state;
      end
   end

   // Unreachable encodings fall into undef so they stand out in waves
   always_comb begin
      next_state = undef;
      unique case (curr_state)
         idle: begin
            // Hold off while the start bit is still being cleared, or the
            // run would start again from the stale level
            if (ctrl.start_operation && !acc.ddr_access_completed &&
                !clear_start_operation) begin
               next_state = ddr_access;
            end else begin
               next_state = idle;
            end
         end
         ddr_access: begin
            if (acc.ddr_access_completed) begin
               next_state = idle;
            end else begin
               next_state = ddr_access;
            end
         end
         default: next_state = undef;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Registered outputs, decoded from next_state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge pr_region_clk or negedge rst_n) begin
      if (!rst_n) begin
         busy                    <= 1'b0;
         start_traffic_generator <= 1'b0;
         clear_start_operation   <= 1'b0;
      end else if (ctrl.clr_io_reg) begin
         busy                    <= 1'b0;
         start_traffic_generator <= 1'b0;
         clear_start_operation   <= 1'b0;
      end else begin
         busy                    <= 1'b0;
         start_traffic_generator <= 1'b0;
         clear_start_operation   <= 1'b0;
         unique case (next_state)
            // Ask the decoder to drop start only on the way out of a run
            idle: clear_start_operation <= (curr_state == ddr_access);
            ddr_access: begin
               busy                    <= 1'b1;
               start_traffic_generator <= 1'b1;
            end
            default: ;
         endcase
      end
   end

   assign ctrl.busy                  = busy;
   assign ctrl.clear_start_operation = clear_start_operation;
   assign acc.start_traffic_generator = start_traffic_generator;

endmodule

//--- logic/persona_reg_decode.sv
// Persona register decoder
`timescale 1ns/1ps

module persona_reg_decode (
   input  logic                                       pr_region_clk,
   input  logic                                       rst_n,
   input  logic [ddr_persona_pkg::reg_addr_width-1:0] reg_address,
   input  logic                                       reg_write,
   input  logic                                       reg_read,
   input  logic [ddr_persona_pkg::data_width-1:0]     reg_writedata,
   output logic [ddr_persona_pkg::data_width-1:0]     reg_readdata,
   persona_ctrl_if.decode                             ctrl,
   input  logic [ddr_persona_pkg::count_width-1:0]    error_count,
   input  logic [ddr_persona_pkg::count_width-1:0]    words_checked,
   input  logic                                       done,
   input  logic                                       pass
);
   import ddr_persona_pkg::*;

   reg_addr_t              addr;
   logic                   write_control;
   logic                   start_bit;
   logic                   inject_bit;
   logic                   clr_pulse;
   logic [data_width-1:0]  base_reg;
   logic [data_width-1:0]  seed_reg;
   logic [count_width-1:0] count_reg;
   logic [data_width-1:0]  control_word;
   logic [data_width-1:0]  status_word;

   assign addr          = reg_addr_t'(reg_address);
   assign write_control = reg_write && (addr == reg_control);

   ////////////////////////////////////////////////////////////
   // Writable registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge pr_region_clk or negedge rst_n) begin
      if (!rst_n) begin
         start_bit  <= 1'b0;
         inject_bit <= 1'b0;
         clr_pulse  <= 1'b0;
         base_reg   <= '0;
         seed_reg   <= '0;
         count_reg  <= '0;
      end else begin
         // The clear bit is never stored, it only fires for one cycle
         clr_pulse <= write_control && reg_writedata[ctrl_clr_bit];
         // A host write beats the controller's request to drop start
         if (write_control) begin
            start_bit  <= reg_writedata[ctrl_start_bit];
            inject_bit <= reg_writedata[ctrl_inject_bit];
         end else if (ctrl.clear_start_operation) begin
            start_bit <= 1'b0;
         end
         if (reg_write) begin
            case (addr)
               reg_base: base_reg <= reg_writedata;
               reg_seed: seed_reg <= reg_writedata;
               // Counts past the memory depth are clamped to a full sweep
               reg_count: begin
                  if (reg_writedata > data_width'(mem_depth)) begin
                     count_reg <= count_width'(mem_depth);
                  end else begin
                     count_reg <= reg_writedata[count_width-1:0];
                  end
               end
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////

   always_comb begin
      control_word                  = '0;
      control_word[ctrl_start_bit]  = start_bit;
      control_word[ctrl_inject_bit] = inject_bit;
      status_word                   = '0;
      status_word[stat_busy_bit]    = ctrl.busy;
      status_word[stat_done_bit]    = done;
      status_word[stat_pass_bit]    = pass;
   end

   // Read data shows up one cycle after the read strobe
   always_ff @(posedge pr_region_clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_readdata <= '0;
      end else if (reg_read) begin
         case (addr)
            reg_control:       reg_readdata <= control_word;
            reg_status:        reg_readdata <= status_word;
            reg_base:          reg_readdata <= base_reg;
            reg_count:         reg_readdata <= data_width'(count_reg);
            reg_seed:          reg_readdata <= seed_reg;
            reg_error_count:   reg_readdata <= data_width'(error_count);
            reg_words_checked: reg_readdata <= data_width'(words_checked);
            default:           reg_readdata <= '0;
         endcase
      end
   end

   // Only the low address bits reach the generator, so the base wraps
   assign ctrl.start_operation = start_bit;
   assign ctrl.clr_io_reg      = clr_pulse;
   assign ctrl.inject_error    = inject_bit;
   assign ctrl.base            = base_reg[mem_addr_width-1:0];
   assign ctrl.count           = count_reg;
   assign ctrl.seed            = seed_reg;

endmodule

//--- logic/persona_ifs.sv
// Persona internal interfaces
`timescale 1ns/1ps

// Control path from the register decoder to execute and result blocks
interface persona_ctrl_if;
   import ddr_persona_pkg::*;

   logic                      start_operation;
   logic                      clr_io_reg;
   logic                      inject_error;
   logic [mem_addr_width-1:0] base;
   logic [count_width-1:0]    count;
   logic [data_width-1:0]     seed;
   logic                      clear_start_operation;
   logic                      busy;

   modport decode (
      output start_operation, clr_io_reg, inject_error, base, count, seed,
      input  clear_start_operation, busy
   );
   modport execute (
      input  start_operation, clr_io_reg,
      output clear_start_operation, busy
   );
   modport generator (input clr_io_reg, inject_error, base, count, seed);
   modport result (input clr_io_reg);
endinterface

// Traffic generator handshake and per-word compare strobes
interface access_result_if;
   logic start_traffic_generator;
   logic check_valid;
   logic mismatch;
   logic ddr_access_completed;

   modport control (output start_traffic_generator, input ddr_access_completed);
   modport generator (
      input  start_traffic_generator,
      output check_valid, mismatch, ddr_access_completed
   );
   modport monitor (
      input start_traffic_generator, check_valid, mismatch, ddr_access_completed
   );
endinterface

//--- logic/ddr_persona_pkg.sv
// DDR persona shared definitions
package ddr_persona_pkg;

   ////////////////////////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////////////////////////

   // On-chip stand-in for DDR has 64 words, addresses wrap modulo 64
   localparam int mem_addr_width = 6;
   localparam int mem_depth      = 1 << mem_addr_width;
   localparam int data_width     = 32;
   // Count register holds 0 to 64 words
   localparam int count_width    = 7;
   localparam int reg_addr_width = 3;

   // Bit positions inside the control register
   localparam int ctrl_start_bit  = 0;
   localparam int ctrl_clr_bit    = 1;
   localparam int ctrl_inject_bit = 2;

   // Bit positions inside the status register
   localparam int stat_busy_bit = 0;
   localparam int stat_done_bit = 1;
   localparam int stat_pass_bit = 2;

   ////////////////////////////////////////////////////////////
   // Register map and state encodings
   ////////////////////////////////////////////////////////////

   typedef enum logic [reg_addr_width-1:0] {
      reg_control       = 3'd0,
      reg_status        = 3'd1,
      reg_base          = 3'd2,
      reg_count         = 3'd3,
      reg_seed          = 3'd4,
      reg_error_count   = 3'd5,
      reg_words_checked = 3'd6
   } reg_addr_t;

   // Controller states follow the original persona controller
   typedef enum logic [1:0] {
      idle,
      ddr_access,
      undef
   } access_state_t;

   typedef enum logic [1:0] {
      gen_idle,
      gen_write,
      gen_read,
      gen_done
   } gen_state_t;

   // Word i of a run holds seed plus i, wrapping at 32 bits
   function automatic logic [data_width-1:0] pattern_word(
      input logic [data_width-1:0]  seed,
      input logic [count_width-1:0] index
   );
      return seed + data_width'(index);
   endfunction

endpackage
